/* source/tcdm_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TCDM cluster package
// Sizes, address fields and vector types
// shared by the interconnect and the banks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package tcdm_pkg;

  // Cluster dimensions
  localparam int unsigned NumIn  = 4;   // Initiators
  localparam int unsigned NumOut = 4;   // Banks

  // Word and address widths
  localparam int unsigned AddrWidth = 16;               // Byte address on initiator side
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;    // One strobe per byte

  // Address split, low to high: byte offset, bank select, row
  localparam int unsigned ByteOffWidth = 2;
  localparam int unsigned BankSelWidth = 2;   // log2 of NumOut
  localparam int unsigned RowWidth     = 6;   // 64 words per bank

  // Initiator index carried with each request
  localparam int unsigned IniIdxWidth = 2;    // log2 of NumIn

  // Request payload routed through the crossbar: wen, be, row, wdata
  localparam int unsigned ReqAggWidth = 1 + BeWidth + RowWidth + DataWidth;

  typedef logic [AddrWidth-1:0]    addr_t;
  typedef logic [DataWidth-1:0]    data_t;
  typedef logic [BeWidth-1:0]      be_t;
  typedef logic [RowWidth-1:0]     row_t;
  typedef logic [BankSelWidth-1:0] tgt_idx_t;    // Bank number
  typedef logic [IniIdxWidth-1:0]  ini_idx_t;    // Initiator number
  typedef logic [ReqAggWidth-1:0]  req_agg_t;

endpackage : tcdm_pkg

`default_nettype wire

/* source/tcdm_req_xbar.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TCDM request crossbar
// Round-robin arbitration per bank over
// the initiators, payload and index muxing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module tcdm_req_xbar import tcdm_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // Initiator side
  input  logic     [NumIn-1:0]          valid_i,
  output logic     [NumIn-1:0]          ready_o,
  input  tgt_idx_t [NumIn-1:0]          tgt_i,    // Addressed bank
  input  req_agg_t [NumIn-1:0]          data_i,   // Aggregated request
  // Bank side
  output logic     [NumOut-1:0]         valid_o,
  input  logic     [NumOut-1:0]         ready_i,
  output ini_idx_t [NumOut-1:0]         ini_o,    // Winning initiator
  output req_agg_t [NumOut-1:0]         data_o
);

  // One-hot grant, bank by initiator
  logic [NumOut-1:0][NumIn-1:0] gnt_oh;

  for (genvar t = 0; t < NumOut; t++) begin : gen_tgt
    logic [NumIn-1:0] req_mask;   // Initiators asking for this bank
    ini_idx_t         rr_ptr_q;   // Initiator with top priority
    ini_idx_t         gnt_idx;
    logic             gnt_vld;

    always_comb begin : find_requests
      for (int i = 0; i < NumIn; i++) begin
        req_mask[i] = valid_i[i] && (tgt_i[i] == tgt_idx_t'(t));
      end
    end

    // Scan from lowest priority up, so the last hit is nearest the pointer
    always_comb begin : pick_winner
      ini_idx_t cand;
      gnt_vld = 1'b0;
      gnt_idx = rr_ptr_q;
      for (int k = NumIn - 1; k >= 0; k--) begin
        cand = rr_ptr_q + ini_idx_t'(k);   // Wraps modulo NumIn
        if (req_mask[cand]) begin
          gnt_vld = 1'b1;
          gnt_idx = cand;
        end
      end
    end

    for (genvar i = 0; i < NumIn; i++) begin : gen_gnt
      assign gnt_oh[t][i] = gnt_vld && (gnt_idx == ini_idx_t'(i));
    end

    assign valid_o[t] = gnt_vld;
    assign ini_o[t]   = gnt_idx;           // Travels with the request for the return path
    assign data_o[t]  = data_i[gnt_idx];

    // Move past the winner once its request is taken
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        rr_ptr_q <= '0;
      end else if (gnt_vld && ready_i[t]) begin
        rr_ptr_q <= gnt_idx + ini_idx_t'(1);
      end
    end
  end : gen_tgt

  // Ready goes back only to the granted initiator of a ready bank
  always_comb begin : route_ready
    ready_o = '0;
    for (int i = 0; i < NumIn; i++) begin
      for (int t = 0; t < NumOut; t++) begin
        if (gnt_oh[t][i] && ready_i[t]) begin
          ready_o[i] = 1'b1;
        end
      end
    end
  end

endmodule : tcdm_req_xbar

`default_nettype wire

/* source/tcdm_resp_xbar.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TCDM response crossbar
// Routes read data back by initiator index,
// round-robin over banks per initiator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module tcdm_resp_xbar import tcdm_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // Bank side
  input  logic     [NumOut-1:0] valid_i,
  output logic     [NumOut-1:0] ready_o,
  input  ini_idx_t [NumOut-1:0] ini_i,     // Destination initiator
  input  data_t    [NumOut-1:0] data_i,
  // Initiator side
  output logic     [NumIn-1:0]  valid_o,
  input  logic     [NumIn-1:0]  ready_i,
  output data_t    [NumIn-1:0]  data_o
);

  logic [NumIn-1:0][NumOut-1:0] gnt_oh;   // Initiator by bank

  for (genvar i = 0; i < NumIn; i++) begin : gen_ini
    logic [NumOut-1:0] rsp_mask;   // Banks holding data for us
    tgt_idx_t          rr_ptr_q;
    tgt_idx_t          gnt_idx;
    logic              gnt_vld;

    always_comb begin : find_responses
      for (int t = 0; t < NumOut; t++) begin
        rsp_mask[t] = valid_i[t] && (ini_i[t] == ini_idx_t'(i));
      end
    end

    // Same priority walk as the request side, over banks
    always_comb begin : pick_winner
      tgt_idx_t cand;
      gnt_vld = 1'b0;
      gnt_idx = rr_ptr_q;
      for (int k = NumOut - 1; k >= 0; k--) begin
        cand = rr_ptr_q + tgt_idx_t'(k);
        if (rsp_mask[cand]) begin
          gnt_vld = 1'b1;
          gnt_idx = cand;
        end
      end
    end

    for (genvar t = 0; t < NumOut; t++) begin : gen_gnt
      assign gnt_oh[i][t] = gnt_vld && (gnt_idx == tgt_idx_t'(t));
    end

    assign valid_o[i] = gnt_vld;
    assign data_o[i]  = data_i[gnt_idx];   // Held by the bank slot while stalled

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        rr_ptr_q <= '0;
      end else if (gnt_vld && ready_i[i]) begin
        rr_ptr_q <= gnt_idx + tgt_idx_t'(1);   // Next bank first
      end
    end
  end : gen_ini

  // Drain only the chosen bank
  always_comb begin : route_ready
    ready_o = '0;
    for (int t = 0; t < NumOut; t++) begin
      for (int i = 0; i < NumIn; i++) begin
        if (gnt_oh[i][t] && ready_i[i]) begin
          ready_o[t] = 1'b1;
        end
      end
    end
  end

endmodule : tcdm_resp_xbar

`default_nettype wire

/* source/variable_latency_interconnect.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Variable latency interconnect
// Address decode plus request and response
// crossbars working side by side
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module variable_latency_interconnect import tcdm_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // Initiator side
  input  logic     [NumIn-1:0]  req_valid_i,
  output logic     [NumIn-1:0]  req_ready_o,
  input  addr_t    [NumIn-1:0]  req_addr_i,     // Byte address
  input  logic     [NumIn-1:0]  req_wen_i,
  input  data_t    [NumIn-1:0]  req_wdata_i,
  input  be_t      [NumIn-1:0]  req_be_i,
  output logic     [NumIn-1:0]  resp_valid_o,
  input  logic     [NumIn-1:0]  resp_ready_i,
  output data_t    [NumIn-1:0]  resp_rdata_o,
  // Bank side
  output logic     [NumOut-1:0] req_valid_o,
  input  logic     [NumOut-1:0] req_ready_i,
  output ini_idx_t [NumOut-1:0] req_ini_o,      // Requesting initiator
  output row_t     [NumOut-1:0] req_row_o,      // Word inside the bank
  output logic     [NumOut-1:0] req_wen_o,
  output data_t    [NumOut-1:0] req_wdata_o,
  output be_t      [NumOut-1:0] req_be_o,
  input  logic     [NumOut-1:0] resp_valid_i,
  output logic     [NumOut-1:0] resp_ready_o,
  input  ini_idx_t [NumOut-1:0] resp_ini_i,
  input  data_t    [NumOut-1:0] resp_rdata_i
);

  tgt_idx_t [NumIn-1:0]  tgt_sel;        // Bank picked by each initiator
  req_agg_t [NumIn-1:0]  data_agg_in;
  req_agg_t [NumOut-1:0] data_agg_out;

  for (genvar j = 0; j < NumIn; j++) begin : gen_inputs
    // Bank select sits just above the byte offset, row above that
    assign tgt_sel[j]     = req_addr_i[j][ByteOffWidth +: BankSelWidth];
    assign data_agg_in[j] = {req_wen_i[j], req_be_i[j],
                             req_addr_i[j][ByteOffWidth + BankSelWidth +: RowWidth],
                             req_wdata_i[j]};
  end

  // Unpack on the bank side, same field order
  for (genvar k = 0; k < NumOut; k++) begin : gen_outputs
    assign {req_wen_o[k], req_be_o[k], req_row_o[k], req_wdata_o[k]} = data_agg_out[k];
  end

  tcdm_req_xbar u_req_xbar (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (req_valid_i),
    .ready_o (req_ready_o),
    .tgt_i   (tgt_sel),
    .data_i  (data_agg_in),
    .valid_o (req_valid_o),
    .ready_i (req_ready_i),
    .ini_o   (req_ini_o),
    .data_o  (data_agg_out)
  );

  tcdm_resp_xbar u_resp_xbar (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (resp_valid_i),
    .ready_o (resp_ready_o),
    .ini_i   (resp_ini_i),     // Return route chosen by request index
    .data_i  (resp_rdata_i),
    .valid_o (resp_valid_o),
    .ready_i (resp_ready_i),
    .data_o  (resp_rdata_o)
  );

endmodule : variable_latency_interconnect

`default_nettype wire

/* source/tcdm_bank.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TCDM bank
// Single-ported word memory with byte
// enables and one held read response slot
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module tcdm_bank import tcdm_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Request
  input  logic     req_valid_i,
  output logic     req_ready_o,
  input  ini_idx_t req_ini_i,
  input  row_t     req_row_i,
  input  logic     req_wen_i,
  input  data_t    req_wdata_i,
  input  be_t      req_be_i,
  // Read response
  output logic     resp_valid_o,
  input  logic     resp_ready_i,
  output ini_idx_t resp_ini_o,
  output data_t    resp_rdata_o
);

  data_t mem_q [2**RowWidth];   // Word storage

  logic     slot_vld_q;         // Response waiting to be drained
  ini_idx_t slot_ini_q;
  data_t    slot_data_q;

  logic req_hs;                 // Request taken this cycle
  logic rd_hs;
  logic wr_hs;
  logic resp_hs;

  // Writes never wait, reads need a free or emptying slot
  assign req_ready_o = req_wen_i || !slot_vld_q || resp_ready_i;

  assign req_hs  = req_valid_i && req_ready_o;
  assign rd_hs   = req_hs && !req_wen_i;
  assign wr_hs   = req_hs && req_wen_i;
  assign resp_hs = slot_vld_q && resp_ready_i;

  // Byte lane writes
  always_ff @(posedge clk_i) begin
    if (wr_hs) begin
      for (int b = 0; b < BeWidth; b++) begin
        if (req_be_i[b]) begin
          mem_q[req_row_i][8*b +: 8] <= req_wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Slot occupancy
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      slot_vld_q <= 1'b0;
    end else if (rd_hs) begin
      slot_vld_q <= 1'b1;           // Refill wins over drain
    end else if (resp_hs) begin
      slot_vld_q <= 1'b0;
    end
  end

  // Slot payload, only loaded by a read
  always_ff @(posedge clk_i) begin
    if (rd_hs) begin
      slot_ini_q  <= req_ini_i;
      slot_data_q <= mem_q[req_row_i];
    end
  end

  assign resp_valid_o = slot_vld_q;
  assign resp_ini_o   = slot_ini_q;    // Return address for the response crossbar
  assign resp_rdata_o = slot_data_q;   // Stable until drained

endmodule : tcdm_bank

`default_nettype wire

/* source/tcdm_cluster_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TCDM cluster top
// Interconnect joined to four memory banks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module tcdm_cluster_top import tcdm_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic [NumIn-1:0]  req_valid_i,
  output logic [NumIn-1:0]  req_ready_o,
  input  addr_t [NumIn-1:0] req_addr_i,
  input  logic [NumIn-1:0]  req_wen_i,
  input  data_t [NumIn-1:0] req_wdata_i,
  input  be_t   [NumIn-1:0] req_be_i,
  output logic [NumIn-1:0]  resp_valid_o,
  input  logic [NumIn-1:0]  resp_ready_i,
  output data_t [NumIn-1:0] resp_rdata_o
);

  // Bank side request
  logic     [NumOut-1:0] bank_req_valid;
  logic     [NumOut-1:0] bank_req_ready;
  ini_idx_t [NumOut-1:0] bank_req_ini;
  row_t     [NumOut-1:0] bank_req_row;
  logic     [NumOut-1:0] bank_req_wen;
  data_t    [NumOut-1:0] bank_req_wdata;
  be_t      [NumOut-1:0] bank_req_be;
  // Bank side response
  logic     [NumOut-1:0] bank_resp_valid;
  logic     [NumOut-1:0] bank_resp_ready;
  ini_idx_t [NumOut-1:0] bank_resp_ini;
  data_t    [NumOut-1:0] bank_resp_rdata;

  variable_latency_interconnect u_interconnect (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_addr_i   (req_addr_i),
    .req_wen_i    (req_wen_i),
    .req_wdata_i  (req_wdata_i),
    .req_be_i     (req_be_i),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_rdata_o (resp_rdata_o),
    .req_valid_o  (bank_req_valid),
    .req_ready_i  (bank_req_ready),
    .req_ini_o    (bank_req_ini),
    .req_row_o    (bank_req_row),
    .req_wen_o    (bank_req_wen),
    .req_wdata_o  (bank_req_wdata),
    .req_be_o     (bank_req_be),
    .resp_valid_i (bank_resp_valid),
    .resp_ready_o (bank_resp_ready),
    .resp_ini_i   (bank_resp_ini),
    .resp_rdata_i (bank_resp_rdata)
  );

  for (genvar t = 0; t < NumOut; t++) begin : gen_banks
    tcdm_bank u_bank (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .req_valid_i  (bank_req_valid[t]),
      .req_ready_o  (bank_req_ready[t]),
      .req_ini_i    (bank_req_ini[t]),
      .req_row_i    (bank_req_row[t]),
      .req_wen_i    (bank_req_wen[t]),
      .req_wdata_i  (bank_req_wdata[t]),
      .req_be_i     (bank_req_be[t]),
      .resp_valid_o (bank_resp_valid[t]),
      .resp_ready_i (bank_resp_ready[t]),
      .resp_ini_o   (bank_resp_ini[t]),
      .resp_rdata_o (bank_resp_rdata[t])
    );
  end

endmodule : tcdm_cluster_top

`default_nettype wire

/* bench/tb_tcdm_cluster.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TCDM cluster testbench
// Table-driven traffic from four initiators,
// memory reference model and random stalls
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`default_nettype none

module tb_tcdm_cluster import tcdm_pkg::*; ();

  localparam int unsigned ClkPeriod   = 40;
  localparam int unsigned ResetCycles = 4;
  localparam int unsigned NumRows     = 18;
  localparam int unsigned RowBudget   = 64;   // Cycles allowed per table row

  typedef struct packed {
    logic  vld;
    logic  wen;
    addr_t addr;
    data_t wdata;
    be_t   be;
  } lane_t;

  logic              clk_i;
  logic              rst_n_i;
  logic [NumIn-1:0]  req_valid_i;
  logic [NumIn-1:0]  req_ready_o;
  addr_t [NumIn-1:0] req_addr_i;
  logic [NumIn-1:0]  req_wen_i;
  data_t [NumIn-1:0] req_wdata_i;
  be_t   [NumIn-1:0] req_be_i;
  logic [NumIn-1:0]  resp_valid_o;
  logic [NumIn-1:0]  resp_ready_i;
  data_t [NumIn-1:0] resp_rdata_o;

  lane_t       table_lane [NumRows][NumIn];   // One stimulus lane per initiator
  logic        table_bp   [NumRows];          // Random resp_ready_i for this row
  data_t       model_mem  [256];              // Indexed by {row, bank}
  logic [31:0] lcg_state;

  tcdm_cluster_top u_dut (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_addr_i   (req_addr_i),
    .req_wen_i    (req_wen_i),
    .req_wdata_i  (req_wdata_i),
    .req_be_i     (req_be_i),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_rdata_o (resp_rdata_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Bits 15:10 carry a tag the decode must ignore
  function automatic addr_t make_addr(input int bank, input int row, input int tag);
    return {tag[5:0], row[5:0], bank[1:0], 2'b00};
  endfunction

  function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input be_t be);
    data_t res;
    res = old_w;
    for (int b = 0; b < BeWidth; b++) begin
      if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];   // Enabled lane takes new byte
    end
    return res;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
  endtask

  task automatic set_lane(input int r, input int i, input logic wen, input addr_t addr,
                          input data_t wdata, input be_t be);
    table_lane[r][i] = {1'b1, wen, addr, wdata, be};
  endtask

  task automatic build_table();
    logic [15:0] be_mix;
    int          b;
    be_mix = 16'hE1A5;   // Partial strobes with lane 0 in the low nibble
    for (int r = 0; r < NumRows; r++) begin
      table_bp[r] = (r >= 11);   // Stalls from the contended reads on
      for (int i = 0; i < NumIn; i++) table_lane[r][i] = '0;
    end
    for (int r = 0; r < 4; r++) begin
      for (int i = 0; i < 4; i++) begin
        set_lane(r, i, 1'b1, make_addr((i + r) % 4, 4*r + i, i + 1), lcg_next(), 4'hF);
        // Read back the word a neighbour wrote
        set_lane(4 + r, i, 1'b0, make_addr((i + 1 + r) % 4, 4*r + (i + 1) % 4, 7), '0, '0);
        b = (7 - i + r) % 4;   // Crossing banks
        set_lane(12 + r, i, 1'b0, make_addr(b, 4*r + (b + 4 - r) % 4, 3), '0, '0);
      end
    end
    for (int i = 0; i < 4; i++) begin
      set_lane(8, i, 1'b1, make_addr(i, i, 9), lcg_next(), be_mix[4*i +: 4]);
      set_lane(9, i, 1'b0, make_addr((i + 2) % 4, (i + 2) % 4, 0), '0, '0);
      set_lane(10, i, 1'b1, make_addr(2, 40 + i, i), lcg_next(), 4'hF);   // All on bank 2
      set_lane(11, i, 1'b0, make_addr(2, 40 + (i + 1) % 4, 5), '0, '0);
    end
    // Reads stalled while writes keep going
    set_lane(16, 0, 1'b0, make_addr(0, 7, 1), '0, '0);
    set_lane(16, 1, 1'b0, make_addr(1, 4, 2), '0, '0);
    set_lane(16, 2, 1'b1, make_addr(0, 50, 3), lcg_next(), 4'hF);
    set_lane(16, 3, 1'b1, make_addr(3, 51, 4), lcg_next(), 4'h3);
    set_lane(17, 0, 1'b0, make_addr(2, 41, 6), '0, '0);
    set_lane(17, 2, 1'b0, make_addr(0, 50, 0), '0, '0);
    set_lane(17, 3, 1'b0, make_addr(3, 51, 2), '0, '0);
  endtask

  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      #(ClkPeriod / 2 - 1);
      assert (resp_valid_o == '0) else begin
        report_failure($sformatf("response with no read issued, resp_valid_o=%h", resp_valid_o));
        $fatal(1);
      end
    end
  endtask

  task automatic run_row(input int r);
    logic [NumIn-1:0] pending_req;   // Lane still waiting for its transfer
    logic [NumIn-1:0] read_busy;     // Read taken and response outstanding
    logic [NumIn-1:0] held_vld;      // Response stalled last cycle
    data_t            exp_data  [NumIn];
    logic [31:0]      lcg_val;
    logic [7:0]       idx;
    read_busy = '0;
    held_vld  = '0;
    for (int i = 0; i < NumIn; i++) pending_req[i] = table_lane[r][i].vld;
    while (pending_req != '0 || read_busy != '0) begin
      @(negedge clk_i);
      lcg_val = lcg_next();
      for (int i = 0; i < NumIn; i++) begin
        req_valid_i[i]  = pending_req[i];
        req_wen_i[i]    = table_lane[r][i].wen;
        req_addr_i[i]   = table_lane[r][i].addr;
        req_wdata_i[i]  = table_lane[r][i].wdata;
        req_be_i[i]     = table_lane[r][i].be;
        resp_ready_i[i] = table_bp[r] ? lcg_val[16 + i] : 1'b1;
      end
      #(ClkPeriod / 2 - 1);   // Just ahead of the rising edge
      for (int i = 0; i < NumIn; i++) begin
        if (resp_valid_o[i]) begin
          assert (read_busy[i]) else begin
            report_failure($sformatf("initiator %0d got a response with no read pending", i));
            $fatal(1);
          end
          // Also checked on stalled cycles so held data must not move
          assert (resp_rdata_o[i] == exp_data[i]) else begin
            report_failure($sformatf("mismatch resp_rdata_o[%0d]: expected %h, got %h",
                                     i, exp_data[i], resp_rdata_o[i]));
            $fatal(1);
          end
          held_vld[i] = !resp_ready_i[i];
          if (resp_ready_i[i]) read_busy[i] = 1'b0;
        end else begin
          assert (!held_vld[i]) else begin
            report_failure($sformatf("initiator %0d response dropped before its transfer", i));
            $fatal(1);
          end
          // Without stalls the data is due one cycle after the request
          assert (table_bp[r] || !read_busy[i]) else begin
            report_failure($sformatf("initiator %0d read not answered in one cycle", i));
            $fatal(1);
          end
        end
      end
      for (int i = 0; i < NumIn; i++) begin
        if (pending_req[i] && req_ready_o[i]) begin
          pending_req[i] = 1'b0;
          idx = table_lane[r][i].addr[9:2];   // Row and bank with the tag dropped
          if (table_lane[r][i].wen) begin
            model_mem[idx] = merge_bytes(model_mem[idx], table_lane[r][i].wdata,
                                         table_lane[r][i].be);
          end else begin
            exp_data[i]  = model_mem[idx];
            read_busy[i] = 1'b1;
          end
        end
      end
    end
  endtask

  initial begin : stimulus
    lcg_state    = 32'd13;
    rst_n_i      = 1'b0;
    req_valid_i  = '0;
    req_addr_i   = '0;
    req_wen_i    = '0;
    req_wdata_i  = '0;
    req_be_i     = '0;
    resp_ready_i = '1;
    build_table();
    repeat (ResetCycles) @(negedge clk_i);
    rst_n_i = 1'b1;
    check_idle(3);
    for (int r = 0; r < NumRows; r++) run_row(r);
    @(negedge clk_i);
    req_valid_i  = '0;
    resp_ready_i = '1;
    check_idle(2);   // Nothing left in flight
    $display("TB PASSED");
    $finish;
  end

  initial begin : watchdog
    repeat (ResetCycles + (NumRows + 2) * RowBudget) @(posedge clk_i);
    report_failure("run hung, table not finished within the cycle budget");
    $fatal(1);
  end

endmodule : tb_tcdm_cluster

`default_nettype wire

/* filelist.f */
source/tcdm_pkg.sv
source/tcdm_req_xbar.sv
source/tcdm_resp_xbar.sv
source/variable_latency_interconnect.sv
source/tcdm_bank.sv
source/tcdm_cluster_top.sv
bench/tb_tcdm_cluster.sv

/* run.sh */
#!/bin/sh
# Build the TCDM cluster testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/10ps \
  -f filelist.f --top-module tb_tcdm_cluster -o sim_tcdm_cluster &&
./obj_dir/sim_tcdm_cluster || {
  echo "simulation failed"
  exit 1
}
